/* include/moxie_consts.svh */
/* Width constants shared by the execute stage packages and RTL.
   Values are fixed for the 32-bit core and are not meant to be overridden per build. */
`ifndef MOXIE_CONSTS_SVH
`define MOXIE_CONSTS_SVH

// Data path and address width
`define MOXIE_XLEN 32
`define MOXIE_REG_IDX_W 4
`define MOXIE_OP_W 6
`define MOXIE_OFFSET_W 10
// Added to the pc when forming a pc-relative branch target
`define MOXIE_INSN_BYTES 2
`define MOXIE_SHAMT_W 5

`endif

/* hdl/moxie_isa_pkg.sv */
/* Instruction set types. Opcodes are the stage's internal 6-bit encoding,
   so the decoder has to map the long and branch formats onto these values. */
`include "moxie_consts.svh"

package moxie_isa_pkg;

  // Values follow the form-1 encoding where one exists
  typedef enum logic [`MOXIE_OP_W-1:0] {
    OP_LDI_L = 6'h01,
    OP_MOV   = 6'h02,
    OP_ADD_L = 6'h05,
    OP_LDA_L = 6'h08,
    OP_STA_L = 6'h09,
    OP_LD_L  = 6'h0a,
    OP_LDO_L = 6'h0c,
    OP_CMP   = 6'h0e,
    OP_NOP   = 6'h0f,
    OP_JMPA  = 6'h1a,
    OP_JMP   = 6'h25,
    OP_AND   = 6'h26,
    OP_LSHR  = 6'h27,
    OP_ASHL  = 6'h28,
    OP_SUB_L = 6'h29,
    OP_NEG   = 6'h2a,
    OP_OR    = 6'h2b,
    OP_NOT   = 6'h2c,
    OP_ASHR  = 6'h2d,
    OP_XOR   = 6'h2e,
    // Conditional pc-relative branches
    OP_BEQ   = 6'h30,
    OP_BNE   = 6'h31,
    OP_BLT   = 6'h32,
    OP_BGT   = 6'h33,
    OP_BLTU  = 6'h34,
    OP_BGTU  = 6'h35,
    OP_BGE   = 6'h36,
    OP_BLE   = 6'h37,
    OP_BGEU  = 6'h38,
    OP_BLEU  = 6'h39,
    OP_INC   = 6'h3a,
    OP_DEC   = 6'h3b
  } opcode_e;

  // Flags written by cmp, signed and unsigned orderings of reg_a against reg_b
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_flags_t;

endpackage

/* hdl/exec_pkg.sv */
/* Packet types of the execute stage. The request carries operands already read
   from the register file, so the stage itself has no register file access. */
`include "moxie_consts.svh"

package exec_pkg;

  // One instruction as handed over by decode
  typedef struct packed {
    moxie_isa_pkg::opcode_e           op;
    logic [`MOXIE_XLEN-1:0]           reg_a;
    logic [`MOXIE_XLEN-1:0]           reg_b;
    logic [`MOXIE_REG_IDX_W-1:0]      idx_a;
    logic [`MOXIE_REG_IDX_W-1:0]      idx_b;
    logic [`MOXIE_XLEN-1:0]           operand;
    logic [`MOXIE_OFFSET_W-1:0]       pcrel_offset;
    logic [`MOXIE_XLEN-1:0]           pc;
  } exec_req_t;

  // Register write-back and memory request
  typedef struct packed {
    logic                             wr_en;
    logic [`MOXIE_REG_IDX_W-1:0]      wr_idx;
    logic [`MOXIE_XLEN-1:0]           wr_data;
    logic                             mem_rd;
    logic                             mem_wr;
    logic [`MOXIE_XLEN-1:0]           mem_addr;
    logic [`MOXIE_XLEN-1:0]           mem_data;
  } exec_res_t;

  typedef struct packed {
    logic                             taken;
    logic [`MOXIE_XLEN-1:0]           target;
  } exec_branch_t;

  // Result packet returned downstream
  typedef struct packed {
    exec_res_t                        res;
    exec_branch_t                     branch;
    logic [`MOXIE_XLEN-1:0]           pc;
  } exec_rsp_t;

endpackage

/* hdl/exec_datapath.sv */
/* Purely combinational. Only word loads and stores are generated, and any
   opcode not decoded here gives no write and no memory request. */
`include "moxie_consts.svh"

module exec_datapath (
  input  exec_pkg::exec_req_t req_i,
  output exec_pkg::exec_res_t res_o
);

  import moxie_isa_pkg::*;

  logic [`MOXIE_SHAMT_W-1:0] shamt;
  logic [`MOXIE_XLEN-1:0]    incdec;
  logic                      wr_en;
  logic [`MOXIE_XLEN-1:0]    wr_data;
  logic                      mem_rd;
  logic                      mem_wr;
  logic [`MOXIE_XLEN-1:0]    mem_addr;
  logic [`MOXIE_XLEN-1:0]    mem_data;

  // Only the low bits of reg_b count as shift amount
  assign shamt  = req_i.reg_b[`MOXIE_SHAMT_W-1:0];
  // inc and dec take their 8-bit constant from the offset field
  assign incdec = {{(`MOXIE_XLEN-8){1'b0}}, req_i.pcrel_offset[7:0]};

  always_comb
  begin
    wr_en = 1'b1;
    case (req_i.op)
      OP_ADD_L: wr_data = req_i.reg_a + req_i.reg_b;
      OP_SUB_L: wr_data = req_i.reg_a - req_i.reg_b;
      OP_AND:   wr_data = req_i.reg_a & req_i.reg_b;
      OP_OR:    wr_data = req_i.reg_a | req_i.reg_b;
      OP_XOR:   wr_data = req_i.reg_a ^ req_i.reg_b;
      OP_ASHL:  wr_data = req_i.reg_a << shamt;
      OP_ASHR:  wr_data = $signed(req_i.reg_a) >>> shamt;
      OP_LSHR:  wr_data = req_i.reg_a >> shamt;
      OP_NEG:   wr_data = -req_i.reg_b;
      OP_NOT:   wr_data = ~req_i.reg_b;
      OP_MOV:   wr_data = req_i.reg_b;
      OP_INC:   wr_data = req_i.reg_a + incdec;
      OP_DEC:   wr_data = req_i.reg_a - incdec;
      OP_LDI_L: wr_data = req_i.operand;
      default:
      begin
        wr_en   = 1'b0;
        wr_data = '0;
      end
    endcase
  end

  always_comb
  begin
    mem_rd   = 1'b0;
    mem_wr   = 1'b0;
    mem_addr = '0;
    mem_data = '0;
    case (req_i.op)
      OP_LD_L:
      begin
        mem_rd   = 1'b1;
        mem_addr = req_i.reg_b;
      end
      OP_LDA_L:
      begin
        mem_rd   = 1'b1;
        mem_addr = req_i.operand;
      end
      OP_LDO_L:
      begin
        mem_rd   = 1'b1;
        mem_addr = req_i.operand + req_i.reg_b;
      end
      OP_STA_L:
      begin
        mem_wr   = 1'b1;
        mem_addr = req_i.operand;
        mem_data = req_i.reg_a;
      end
      default: ;
    endcase
  end

  assign res_o = '{wr_en: wr_en, wr_idx: req_i.idx_a, wr_data: wr_data,
                   mem_rd: mem_rd, mem_wr: mem_wr, mem_addr: mem_addr,
                   mem_data: mem_data};

endmodule

/* hdl/exec_branch.sv */
/* Flags are written only when commit_i is high for a cmp, so branches read the
   flags of the last committed cmp. Offsets are zero-extended, backward branches need jmp. */
`include "moxie_consts.svh"

module exec_branch (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   commit_i,
  input  exec_pkg::exec_req_t    req_i,
  output exec_pkg::exec_branch_t branch_o
);

  import moxie_isa_pkg::*;

  cc_flags_t              cc_q;
  cc_flags_t              cc_new;
  logic                   cond;
  logic [`MOXIE_XLEN-1:0] pcrel_target;

  assign cc_new.eq  = req_i.reg_a == req_i.reg_b;
  assign cc_new.lt  = $signed(req_i.reg_a) < $signed(req_i.reg_b);
  assign cc_new.gt  = $signed(req_i.reg_a) > $signed(req_i.reg_b);
  assign cc_new.ltu = req_i.reg_a < req_i.reg_b;
  assign cc_new.gtu = req_i.reg_a > req_i.reg_b;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      cc_q <= '0;
    else if (commit_i && req_i.op == OP_CMP)
      cc_q <= cc_new;
  end

  // Offset counts half-words past the end of the branch instruction
  assign pcrel_target = req_i.pc
                      + {{(`MOXIE_XLEN-`MOXIE_OFFSET_W-1){1'b0}}, req_i.pcrel_offset, 1'b0}
                      + `MOXIE_XLEN'(`MOXIE_INSN_BYTES);

  always_comb
  begin
    cond            = 1'b0;
    branch_o.target = pcrel_target;
    case (req_i.op)
      OP_BEQ:  cond = cc_q.eq;
      OP_BNE:  cond = ~cc_q.eq;
      OP_BLT:  cond = cc_q.lt;
      OP_BLTU: cond = cc_q.ltu;
      OP_BGT:  cond = cc_q.gt;
      OP_BGTU: cond = cc_q.gtu;
      OP_BLE:  cond = cc_q.eq | cc_q.lt;
      OP_BGE:  cond = cc_q.eq | cc_q.gt;
      OP_BLEU: cond = cc_q.eq | cc_q.ltu;
      OP_BGEU: cond = cc_q.eq | cc_q.gtu;
      OP_JMP:
      begin
        cond            = 1'b1;
        branch_o.target = req_i.reg_a;
      end
      OP_JMPA:
      begin
        cond            = 1'b1;
        branch_o.target = req_i.operand;
      end
      default: branch_o.target = '0;
    endcase
    branch_o.taken = cond;
  end

endmodule

/* hdl/exec_retire.sv */
/* One-entry output register, so a new instruction is taken only when the slot is
   free or drains in the same cycle. The instruction after a taken branch is dropped. */
`include "moxie_consts.svh"

module exec_retire (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  exec_pkg::exec_res_t    res_i,
  input  exec_pkg::exec_branch_t branch_i,
  input  logic [`MOXIE_XLEN-1:0] pc_i,
  output logic                   commit_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output exec_pkg::exec_rsp_t    out_rsp_o
);

  import exec_pkg::*;

  logic      out_valid_q;
  logic      squash_q;
  logic      accept;
  exec_rsp_t rsp_q;

  assign in_ready_o = ~out_valid_q | out_ready_i;
  assign accept     = in_valid_i & in_ready_o;
  // A squashed instruction is still accepted, it just leaves no trace
  assign commit_o   = accept & ~squash_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      out_valid_q <= 1'b0;
      squash_q    <= 1'b0;
    end
    else
    begin
      if (accept)
        squash_q <= commit_o & branch_i.taken;
      out_valid_q <= commit_o | (out_valid_q & ~out_ready_i);
    end
  end

  // Payload only, qualified by out_valid_q
  always_ff @(posedge clk_i)
  begin
    if (commit_o)
      rsp_q <= '{res: res_i, branch: branch_i, pc: pc_i};
  end

  assign out_valid_o = out_valid_q;
  assign out_rsp_o   = rsp_q;

endmodule

/* hdl/exec_stage.sv */
/* Execute stage top. One result register, so at most one instruction is in flight
   and a committed instruction shows up on out_rsp_o one cycle after acceptance. */
module exec_stage (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  exec_pkg::exec_req_t in_req_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output exec_pkg::exec_rsp_t out_rsp_o
);

  import exec_pkg::*;

  exec_res_t    res;
  exec_branch_t branch;
  logic         commit;

  exec_datapath u_datapath (
    .req_i (in_req_i),
    .res_o (res)
  );

  // Condition codes advance only on committed cmp instructions
  exec_branch u_branch (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .commit_i (commit),
    .req_i    (in_req_i),
    .branch_o (branch)
  );

  exec_retire u_retire (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .res_i       (res),
    .branch_i    (branch),
    .pc_i        (in_req_i.pc),
    .commit_o    (commit),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_rsp_o   (out_rsp_o)
  );

endmodule

/* tb/exec_stage_assert.sv */
/* Handshake and reset properties of exec_stage, attached by bind from the testbench.
   Properties other than the reset one are disabled while rst_i is high. */
module exec_stage_assert (
  input logic                clk_i,
  input logic                rst_i,
  input logic                in_ready_o,
  input logic                out_valid_o,
  input logic                out_ready_i,
  input exec_pkg::exec_rsp_t out_rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // A result waits for downstream
  logic stalled;

  assign stalled = out_valid_o && !out_ready_i;

  reset_empty: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else $error("out_valid_o is high in the cycle after reset");

  // Held result keeps valid and payload
  hold_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
                             stalled |=> out_valid_o && $stable(out_rsp_o))
    else $error("out_rsp_o changed while waiting for out_ready_i");

  no_accept: assert property (@(posedge clk_i) disable iff (rst_i)
                              stalled |-> !in_ready_o)
    else $error("in_ready_o is high while the result register is held");

endmodule

/* tb/tb_exec_stage.sv */
/* Table-driven testbench for exec_stage with a reference model of the stage rules.
   Back-pressure and some operands come from an LFSR with a fixed seed. */
`include "moxie_consts.svh"

module tb_exec_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import moxie_isa_pkg::*;
  import exec_pkg::*;

  logic        clk_i;
  logic        rst_i;
  logic        in_valid_i;
  logic        in_ready_o;
  exec_req_t   in_req_i;
  logic        out_valid_o;
  logic        out_ready_i;
  exec_rsp_t   out_rsp_o;

  logic [31:0] lfsr_q;
  exec_req_t   table_q[$];
  logic        rnd_q[$];
  exec_rsp_t   want_q[$];
  cc_flags_t   model_cc;
  logic        model_squash;
  opcode_e     br_ops[10];
  int          errors;
  int          received;
  int          squashed;
  int          limit_cycles;

  exec_stage DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_req_i    (in_req_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_rsp_o   (out_rsp_o)
  );

  bind exec_stage exec_stage_assert u_assert (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_rsp_o   (out_rsp_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = rand_bits(1);
    return v[0];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, want);
    end
  endtask

  // Row indices and pc follow from the row number
  task automatic add_row(input opcode_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] operand, input logic [9:0] off, input logic rnd);
    exec_req_t r;
    r.op           = op;
    r.reg_a        = a;
    r.reg_b        = b;
    r.idx_a        = 4'(table_q.size() % 16);
    r.idx_b        = 4'((table_q.size() + 5) % 16);
    r.operand      = operand;
    r.pcrel_offset = off;
    r.pc           = 32'h0000_2000 + 32'(4 * table_q.size());
    table_q.push_back(r);
    rnd_q.push_back(rnd);
  endtask

  // Expected packet of one accepted instruction including squash and flag state
  task automatic model_row(input exec_req_t req);
    exec_rsp_t              want;
    logic [`MOXIE_XLEN-1:0] pcrel;
    want             = '0;
    want.pc          = req.pc;
    want.res.wr_idx  = req.idx_a;
    want.res.wr_en   = 1'b1;
    case (req.op)
      OP_ADD_L: want.res.wr_data = req.reg_a + req.reg_b;
      OP_SUB_L: want.res.wr_data = req.reg_a - req.reg_b;
      OP_AND:   want.res.wr_data = req.reg_a & req.reg_b;
      OP_OR:    want.res.wr_data = req.reg_a | req.reg_b;
      OP_XOR:   want.res.wr_data = req.reg_a ^ req.reg_b;
      OP_ASHL:  want.res.wr_data = req.reg_a << req.reg_b[4:0];
      OP_ASHR:  want.res.wr_data = $signed(req.reg_a) >>> req.reg_b[4:0];
      OP_LSHR:  want.res.wr_data = req.reg_a >> req.reg_b[4:0];
      OP_NEG:   want.res.wr_data = 32'h0 - req.reg_b;
      OP_NOT:   want.res.wr_data = ~req.reg_b;
      OP_MOV:   want.res.wr_data = req.reg_b;
      OP_INC:   want.res.wr_data = req.reg_a + 32'(req.pcrel_offset[7:0]);
      OP_DEC:   want.res.wr_data = req.reg_a - 32'(req.pcrel_offset[7:0]);
      OP_LDI_L: want.res.wr_data = req.operand;
      default:  want.res.wr_en = 1'b0;
    endcase
    want.res.mem_rd = req.op inside {OP_LD_L, OP_LDA_L, OP_LDO_L};
    want.res.mem_wr = req.op == OP_STA_L;
    case (req.op)
      OP_LD_L:            want.res.mem_addr = req.reg_b;
      OP_LDA_L, OP_STA_L: want.res.mem_addr = req.operand;
      OP_LDO_L:           want.res.mem_addr = req.operand + req.reg_b;
      default: ;
    endcase
    if (want.res.mem_wr)
      want.res.mem_data = req.reg_a;
    pcrel = req.pc + 32'(req.pcrel_offset) * 2 + `MOXIE_INSN_BYTES;
    case (req.op)
      OP_BEQ:          want.branch.taken = model_cc.eq;
      OP_BNE:          want.branch.taken = !model_cc.eq;
      OP_BLT:          want.branch.taken = model_cc.lt;
      OP_BLTU:         want.branch.taken = model_cc.ltu;
      OP_BGT:          want.branch.taken = model_cc.gt;
      OP_BGTU:         want.branch.taken = model_cc.gtu;
      OP_BLE:          want.branch.taken = model_cc.lt || model_cc.eq;
      OP_BGE:          want.branch.taken = model_cc.gt || model_cc.eq;
      OP_BLEU:         want.branch.taken = model_cc.ltu || model_cc.eq;
      OP_BGEU:         want.branch.taken = model_cc.gtu || model_cc.eq;
      OP_JMP, OP_JMPA: want.branch.taken = 1'b1;
      default: ;
    endcase
    if (req.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BLTU, OP_BGT, OP_BGTU,
                       OP_BLE, OP_BGE, OP_BLEU, OP_BGEU})
      want.branch.target = pcrel;
    else if (req.op == OP_JMP)
      want.branch.target = req.reg_a;
    else if (req.op == OP_JMPA)
      want.branch.target = req.operand;
    if (model_squash)
    begin
      model_squash = 1'b0;
      squashed++;
    end
    else
    begin
      want_q.push_back(want);
      model_squash = want.branch.taken;
      if (req.op == OP_CMP)
      begin
        model_cc.eq  = req.reg_a == req.reg_b;
        model_cc.lt  = $signed(req.reg_a) < $signed(req.reg_b);
        model_cc.gt  = $signed(req.reg_a) > $signed(req.reg_b);
        model_cc.ltu = req.reg_a < req.reg_b;
        model_cc.gtu = req.reg_a > req.reg_b;
      end
    end
  endtask

  task automatic compare_rsp(input exec_rsp_t want);
    check("wr_en", 32'(out_rsp_o.res.wr_en), 32'(want.res.wr_en));
    check("wr_idx", 32'(out_rsp_o.res.wr_idx), 32'(want.res.wr_idx));
    check("wr_data", out_rsp_o.res.wr_data, want.res.wr_data);
    check("mem_rd", 32'(out_rsp_o.res.mem_rd), 32'(want.res.mem_rd));
    check("mem_wr", 32'(out_rsp_o.res.mem_wr), 32'(want.res.mem_wr));
    check("mem_addr", out_rsp_o.res.mem_addr, want.res.mem_addr);
    check("mem_data", out_rsp_o.res.mem_data, want.res.mem_data);
    check("taken", 32'(out_rsp_o.branch.taken), 32'(want.branch.taken));
    check("target", out_rsp_o.branch.target, want.branch.target);
    check("pc", out_rsp_o.pc, want.pc);
  endtask

  // Results are taken on the clock edge where valid and ready are both high
  initial
  begin
    forever
    begin
      @(posedge clk_i);
      if (!rst_i && out_valid_o && out_ready_i)
      begin
        received++;
        if (want_q.size() == 0)
        begin
          errors++;
          $display("Unexpected result packet with pc %h, none was expected", out_rsp_o.pc);
        end
        else
          compare_rsp(want_q.pop_front());
      end
    end
  end

  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout after %0d cycles, %0d expected packets never arrived",
             limit_cycles, want_q.size());
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    exec_req_t   req;
    logic        acc;
    logic        drop;
    logic        slot_full;
    logic [31:0] pa[3];
    logic [31:0] pb[3];
    rst_i        = 1'b1;
    in_valid_i   = 1'b0;
    in_req_i     = '0;
    out_ready_i  = 1'b0;
    lfsr_q       = 32'hcdb29ab3;
    model_cc     = '0;
    model_squash = 1'b0;
    slot_full    = 1'b0;
    errors       = 0;
    received     = 0;
    squashed     = 0;
    limit_cycles = 0;
    br_ops = '{OP_BEQ, OP_BNE, OP_BLT, OP_BLTU, OP_BGT, OP_BGTU, OP_BLE, OP_BGE, OP_BLEU, OP_BGEU};
    // Signed less, signed greater but unsigned less, equal
    pa = '{32'hffff_fffb, 32'h0000_0003, 32'h0000_0007};
    pb = '{32'h0000_0003, 32'h8000_0000, 32'h0000_0007};
    add_row(OP_ADD_L, 32'h0000_1234, 32'h0000_0011, 32'h0, 10'h0, 1'b0);
    add_row(OP_ADD_L, 32'h0, 32'h0, 32'h0, 10'h0, 1'b1);
    add_row(OP_SUB_L, 32'h0000_0010, 32'h0000_0020, 32'h0, 10'h0, 1'b0);
    add_row(OP_AND, 32'h0, 32'h0, 32'h0, 10'h0, 1'b1);
    add_row(OP_OR, 32'hf0f0_0000, 32'h0000_0f0f, 32'h0, 10'h0, 1'b0);
    add_row(OP_XOR, 32'h0, 32'h0, 32'h0, 10'h0, 1'b1);
    add_row(OP_ASHL, 32'h1234_5678, 32'h0000_0023, 32'h0, 10'h0, 1'b0);
    add_row(OP_ASHR, 32'h8000_00f0, 32'h0000_0024, 32'h0, 10'h0, 1'b0);
    add_row(OP_LSHR, 32'h8000_00f0, 32'h0000_0044, 32'h0, 10'h0, 1'b0);
    add_row(OP_NEG, 32'h0, 32'h0000_0005, 32'h0, 10'h0, 1'b0);
    add_row(OP_NOT, 32'h0, 32'h00ff_00ff, 32'h0, 10'h0, 1'b0);
    add_row(OP_MOV, 32'h1111_1111, 32'hcafe_f00d, 32'h0, 10'h0, 1'b0);
    add_row(OP_INC, 32'h0000_0100, 32'h0, 32'h0, 10'h3ff, 1'b0);
    add_row(OP_DEC, 32'h0000_0100, 32'h0, 32'h0, 10'h105, 1'b0);
    add_row(OP_LDI_L, 32'h0, 32'h0, 32'hdead_beef, 10'h0, 1'b0);
    add_row(OP_LD_L, 32'h0, 32'h0000_4000, 32'h0, 10'h0, 1'b0);
    add_row(OP_LDA_L, 32'h0, 32'h0, 32'h0000_5000, 10'h0, 1'b0);
    add_row(OP_LDO_L, 32'h0, 32'h0000_0010, 32'h0000_6000, 10'h0, 1'b0);
    add_row(OP_STA_L, 32'h5555_aaaa, 32'h0, 32'h0000_7000, 10'h0, 1'b0);
    add_row(OP_NOP, 32'h1, 32'h2, 32'h3, 10'h4, 1'b0);
    add_row(opcode_e'(6'h3f), 32'h1, 32'h2, 32'h3, 10'h4, 1'b0);
    add_row(opcode_e'(6'h00), 32'h1, 32'h2, 32'h3, 10'h4, 1'b0);
    // Each branch is followed by a row that a taken branch squashes
    for (int p = 0; p < 3; p++)
    begin
      add_row(OP_CMP, pa[p], pb[p], 32'h0, 10'h0, 1'b0);
      for (int j = 0; j < 10; j++)
      begin
        add_row(br_ops[j], 32'h0, 32'h0, 32'h0, 10'(16 * j + p), 1'b0);
        add_row(OP_ADD_L, 32'h1, 32'h2, 32'h0, 10'h0, 1'b0);
      end
    end
    add_row(OP_CMP, 32'h5, 32'h5, 32'h0, 10'h0, 1'b0);
    add_row(OP_JMP, 32'h0000_4400, 32'h0, 32'h0, 10'h0, 1'b0);
    add_row(OP_ADD_L, 32'h1, 32'h2, 32'h0, 10'h0, 1'b0);
    add_row(OP_JMPA, 32'h0, 32'h0, 32'h0000_8800, 10'h0, 1'b0);
    // Squashed cmp must leave the equal flags in place
    add_row(OP_CMP, 32'h1, 32'h2, 32'h0, 10'h0, 1'b0);
    add_row(OP_BEQ, 32'h0, 32'h0, 32'h0, 10'h3ff, 1'b0);
    add_row(OP_MOV, 32'h0, 32'h7, 32'h0, 10'h0, 1'b0);
    add_row(OP_BLT, 32'h0, 32'h0, 32'h0, 10'h021, 1'b0);
    for (int k = 0; k < 10; k++)
    begin
      add_row(OP_CMP, 32'h0, 32'h0, 32'h0, 10'h0, 1'b1);
      add_row(br_ops[k], 32'h0, 32'h0, 32'h0, 10'(37 * k), 1'b0);
      add_row(OP_XOR, 32'h0, 32'h0, 32'h0, 10'h0, 1'b1);
    end
    limit_cycles = 20 * table_q.size() + 100;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < table_q.size(); i++)
    begin
      req = table_q[i];
      if (rnd_q[i])
      begin
        req.reg_a = rand_bits(32);
        req.reg_b = rand_bits(32);
      end
      // A row after a taken branch never fills the result register
      drop = model_squash;
      model_row(req);
      in_valid_i = 1'b1;
      in_req_i   = req;
      acc        = 1'b0;
      while (!acc)
      begin
        out_ready_i = rand_bit();
        @(posedge clk_i);
        // Result register is free when empty or drained on this edge
        check("out_valid_o", 32'(out_valid_o), 32'(slot_full));
        check("in_ready_o", 32'(in_ready_o), 32'(!slot_full || out_ready_i));
        acc       = in_ready_o;
        slot_full = (acc && !drop) || (slot_full && !out_ready_i);
        @(negedge clk_i);
      end
    end
    in_valid_i = 1'b0;
    while (want_q.size() != 0)
    begin
      out_ready_i = rand_bit();
      @(negedge clk_i);
    end
    // A few more ready cycles expose packets nobody expected
    out_ready_i = 1'b1;
    repeat (4) @(negedge clk_i);
    check("packet_count", 32'(received), 32'(table_q.size() - squashed));

    $display("Errors: %0d, packets received: %0d, rows squashed: %0d",
             errors, received, squashed);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* moxie_exec.f */
+incdir+include
hdl/moxie_isa_pkg.sv
hdl/exec_pkg.sv
hdl/exec_datapath.sv
hdl/exec_branch.sv
hdl/exec_retire.sv
hdl/exec_stage.sv
tb/exec_stage_assert.sv
tb/tb_exec_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the exec_stage testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_exec_stage \
  -f moxie_exec.f \
  -o sim_exec_stage

./obj_dir/sim_exec_stage | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
  echo "RESULT: PASS"
else
  echo "RESULT: FAIL"
  exit 1
fi
